/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sd_cache -f sources.f -o tb_sd_cache

output=$(./obj_dir/tb_sd_cache 2>&1) || true
echo "$output"

if grep -qx '>>> PASS' <<< "$output"; then
    exit 0
fi
exit 1

/* sim/sd_cache_props.sv */
// Bound assertions on bus strobes, stall stability and the CPU handshake
`timescale 1ns/1ps

module sd_cache_props (
    input logic              osc_50,
    input logic              reset_50m,
    input logic              i_sd_command,
    input logic              o_sd_response,
    input sd_pkg::reg_addr_t o_avm_address,
    input logic              o_avm_read,
    input logic              o_avm_write,
    input sd_pkg::byte_en_t  o_avm_byteenable,
    input sd_pkg::word_t     o_avm_writedata,
    input logic              i_avm_waitrequest
);

    // Strobes drop for at least one cycle after each transfer
    assert property (@(posedge osc_50) disable iff (reset_50m)
        (o_avm_read || o_avm_write) && !i_avm_waitrequest |=>
        !o_avm_read && !o_avm_write)
        else $error("bus strobe stayed high right after a completed transfer");

    // A stalled transfer keeps every bus output
    assert property (@(posedge osc_50) disable iff (reset_50m)
        (o_avm_read || o_avm_write) && i_avm_waitrequest |=>
        $stable(o_avm_address) && $stable(o_avm_byteenable) &&
        $stable(o_avm_writedata) && $stable(o_avm_read) && $stable(o_avm_write))
        else $error("bus outputs changed during waitrequest");

    assert property (@(posedge osc_50) disable iff (reset_50m)
        $rose(o_sd_response) |-> i_sd_command)
        else $error("response rose without a command");

endmodule

bind sd_cache_top sd_cache_props u_props (
    .osc_50            (osc_50),
    .reset_50m         (reset_50m),
    .i_sd_command      (i_sd_command),
    .o_sd_response     (o_sd_response),
    .o_avm_address     (o_avm_address),
    .o_avm_read        (o_avm_read),
    .o_avm_write       (o_avm_write),
    .o_avm_byteenable  (o_avm_byteenable),
    .o_avm_writedata   (o_avm_writedata),
    .i_avm_waitrequest (i_avm_waitrequest)
);

/* sim/sd_core_model.sv */
// Behavioural SD host core with registers, transfer buffer and a 16-sector card memory
`timescale 1ns/1ps

module sd_core_model #(
    parameter sd_pkg::word_t FILL = 32'h0
) (
    input  logic              osc_50,
    input  logic              reset_50m,
    input  sd_pkg::reg_addr_t i_address,
    input  logic              i_read,
    input  logic              i_write,
    input  sd_pkg::byte_en_t  i_byteenable,
    input  sd_pkg::word_t     i_writedata,
    output sd_pkg::word_t     o_readdata,
    output logic              o_waitrequest,
    input  logic              i_stall,
    input  logic              i_fail_cmd
);
    import sd_pkg::*;

    word_t       mem [0:2047];
    word_t       buffer [0:127];
    word_t       arg_reg;
    word_t       last_cmd;
    word_t       wr_arg;
    int          rd_cmds;
    int          wr_cmds;
    int          polls;
    int          busy_cnt;
    logic        err_flag;
    logic        err_used;
    logic        present_seen;
    logic [3:0]  sec;
    logic        fire;
    word_t       lanes;
    word_t       cmd_word;

    // Bit mask of the byte lanes enabled on the bus
    function automatic word_t lane_mask(input byte_en_t be);
        word_t m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    assign o_waitrequest = i_stall;
    assign fire = (i_read || i_write) && !i_stall;
    assign lanes    = lane_mask(i_byteenable);
    assign cmd_word = i_writedata & lanes;

    // Card sector selected by the byte argument modulo 16
    assign sec = arg_reg[SECTOR_BYTE_SHIFT+3:SECTOR_BYTE_SHIFT];

    always_comb begin
        o_readdata = '0;
        if (!i_address[7]) begin
            o_readdata = buffer[i_address[6:0]];
        end else if (i_address == ASR) begin
            o_readdata[ASR_VALID]   = 1'b1;
            o_readdata[ASR_PRESENT] = (polls >= 3);
            o_readdata[ASR_BUSY]    = (busy_cnt != 0);
            o_readdata[ASR_ERROR]   = err_flag;
        end
        o_readdata = o_readdata & lanes;
    end

    always @(posedge osc_50) begin
        if (reset_50m) begin
            for (int i = 0; i < 2048; i++) begin
                mem[i] <= word_t'(i) ^ FILL;
            end
            arg_reg      <= '0;
            last_cmd     <= '0;
            wr_arg       <= '0;
            rd_cmds      <= 0;
            wr_cmds      <= 0;
            polls        <= 0;
            busy_cnt     <= 0;
            err_flag     <= 1'b0;
            err_used     <= 1'b0;
            present_seen <= 1'b0;
        end else if (fire && i_write) begin
            if (!i_address[7]) begin
                buffer[i_address[6:0]] <= (buffer[i_address[6:0]] & ~lanes) |
                                          (i_writedata & lanes);
            end else if (i_address == CMD_ARG) begin
                arg_reg <= (arg_reg & ~lanes) | (i_writedata & lanes);
            end else if (i_address == CMD) begin
                last_cmd <= cmd_word;
                busy_cnt <= 2;
                if (cmd_word == READ_BLOCK) begin
                    rd_cmds <= rd_cmds + 1;
                end else if (cmd_word == WRITE_BLOCK) begin
                    wr_cmds <= wr_cmds + 1;
                    wr_arg  <= arg_reg;
                end
                // An injected failure moves no data
                if (i_fail_cmd && !err_used) begin
                    err_flag <= 1'b1;
                    err_used <= 1'b1;
                end else if (cmd_word == READ_BLOCK) begin
                    for (int w = 0; w < 128; w++) begin
                        buffer[w] <= mem[{sec, offset_t'(w)}];
                    end
                end else if (cmd_word == WRITE_BLOCK) begin
                    for (int w = 0; w < 128; w++) begin
                        mem[{sec, offset_t'(w)}] <= buffer[w];
                    end
                end
            end
        end else if (fire && i_address == ASR) begin
            polls    <= polls + 1;
            err_flag <= 1'b0;
            if (polls >= 3) begin
                present_seen <= 1'b1;
            end
            if (busy_cnt != 0) begin
                busy_cnt <= busy_cnt - 1;
            end
        end
    end

endmodule

/* sim/tb_sd_cache.sv */
// Testbench with clock, reset, directed and random requests, reference model and checks
`timescale 1ns/1ps

module tb_sd_cache;
    import sd_pkg::*;

    localparam word_t       FILL_PATTERN = 32'h3c5a_9e17;
    localparam logic [31:0] SEED         = 32'h5b56;
    localparam int          NUM_RANDOM   = 60;
    localparam int          NUM_REQ      = 7 + NUM_RANDOM;
    localparam int          MAX_CYCLES   = 400 * NUM_REQ;

    logic        osc_50;
    logic        reset_50m;
    logic        sd_command;
    logic        sd_write;
    word_addr_t  sd_address;
    word_t       sd_data_write;
    logic        sd_response;
    word_t       sd_data_read;
    reg_addr_t   avm_address;
    logic        avm_read;
    logic        avm_write;
    byte_en_t    avm_byteenable;
    word_t       avm_writedata;
    word_t       avm_readdata;
    logic        avm_waitrequest;
    logic        stall;
    logic        fail_cmd;
    logic [31:0] stim_state;
    logic [31:0] stall_state;
    word_t       shadow [word_addr_t];
    word_t       expected_data;
    logic        resp_q;
    int          resp_low_cycles;
    int          data_reads;
    int          data_errors;
    int          count_errors;
    int          protocol_errors;
    int          rd_base;
    int          wr_base;
    int          cycles;

    sd_cache_top dut (
        .osc_50            (osc_50),
        .reset_50m         (reset_50m),
        .i_sd_command      (sd_command),
        .i_sd_write        (sd_write),
        .i_sd_address      (sd_address),
        .i_sd_data_write   (sd_data_write),
        .o_sd_response     (sd_response),
        .o_sd_data_read    (sd_data_read),
        .o_avm_address     (avm_address),
        .o_avm_read        (avm_read),
        .o_avm_write       (avm_write),
        .o_avm_byteenable  (avm_byteenable),
        .o_avm_writedata   (avm_writedata),
        .i_avm_readdata    (avm_readdata),
        .i_avm_waitrequest (avm_waitrequest)
    );

    sd_core_model #(.FILL(FILL_PATTERN)) core (
        .osc_50        (osc_50),
        .reset_50m     (reset_50m),
        .i_address     (avm_address),
        .i_read        (avm_read),
        .i_write       (avm_write),
        .i_byteenable  (avm_byteenable),
        .i_writedata   (avm_writedata),
        .o_readdata    (avm_readdata),
        .o_waitrequest (avm_waitrequest),
        .i_stall       (stall),
        .i_fail_cmd    (fail_cmd)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Last CPU write to the word or else the initial card contents
    function automatic word_t expect_word(input word_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return word_t'(a) ^ FILL_PATTERN;
    endfunction

    // One four-phase request that returns once the response is low again
    task automatic run_request(input logic wr, input word_addr_t addr, input word_t data);
        @(posedge osc_50);
        sd_command    <= 1'b1;
        sd_write      <= wr;
        sd_address    <= addr;
        sd_data_write <= data;
        if (wr) begin
            shadow[addr] = data;
        end
        do @(posedge osc_50); while (!sd_response);
        sd_command <= 1'b0;
        do @(posedge osc_50); while (sd_response);
    endtask

    task automatic mark_counts();
        rd_base = core.rd_cmds;
        wr_base = core.wr_cmds;
    endtask

    task automatic check_commands(input int exp_rd, input int exp_wr);
        if (core.rd_cmds - rd_base != exp_rd) begin
            count_errors++;
            $display("Fail t=%0t READ_BLOCK count got %0d expected %0d",
                     $time, core.rd_cmds - rd_base, exp_rd);
        end
        if (core.wr_cmds - wr_base != exp_wr) begin
            count_errors++;
            $display("Fail t=%0t WRITE_BLOCK count got %0d expected %0d",
                     $time, core.wr_cmds - wr_base, exp_wr);
        end
    endtask

    initial begin
        osc_50 = 1'b0;
        forever #4 osc_50 = ~osc_50;
    end

    // Random waitrequest stalls on about one cycle in four
    always @(posedge osc_50) begin
        stall_state <= lcg_next(stall_state);
        stall       <= (stall_state[17:16] == 2'b00);
    end

    always @(posedge osc_50) begin
        if (reset_50m) begin
            resp_q          <= 1'b0;
            resp_low_cycles <= 0;
        end else begin
            resp_q <= sd_response;
            if (sd_response && !resp_q && !sd_write) begin
                expected_data = expect_word(sd_address);
                data_reads++;
                if (sd_data_read !== expected_data) begin
                    data_errors++;
                    $display("Fail t=%0t o_sd_data_read got %h expected %h",
                             $time, sd_data_read, expected_data);
                end
            end
            if (sd_response && !sd_command) begin
                resp_low_cycles <= resp_low_cycles + 1;
            end else begin
                resp_low_cycles <= 0;
            end
            if (sd_response && !sd_command && resp_low_cycles >= 2) begin
                protocol_errors++;
                $display("Response stayed high over 2 cycles after the command dropped");
            end
            if (avm_write && avm_address == CMD && !core.present_seen) begin
                protocol_errors++;
                $display("CMD was written before the card reported present");
            end
            if (sd_response && !core.present_seen) begin
                protocol_errors++;
                $display("Response came before the card reported present");
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge osc_50);
            cycles++;
        end
        $display("Timeout after %0d cycles, a request got no response", cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        word_t       wdata;
        logic [31:0] r;
        reset_50m       = 1'b1;
        sd_command      = 1'b0;
        sd_write        = 1'b0;
        sd_address      = '0;
        sd_data_write   = '0;
        stall           = 1'b0;
        fail_cmd        = 1'b0;
        stim_state      = SEED;
        stall_state     = SEED;
        data_reads      = 0;
        data_errors     = 0;
        count_errors    = 0;
        protocol_errors = 0;
        repeat (4) @(posedge osc_50);
        reset_50m <= 1'b0;

        // The first read is raised while start-up polling is still running
        mark_counts();
        run_request(1'b0, {sector_t'(1), offset_t'(5)}, '0);
        check_commands(1, 0);

        // Read hit
        mark_counts();
        run_request(1'b0, {sector_t'(1), offset_t'(77)}, '0);
        check_commands(0, 0);

        // Write hit then read back
        stim_state = lcg_next(stim_state);
        wdata      = stim_state;
        mark_counts();
        run_request(1'b1, {sector_t'(1), offset_t'(20)}, wdata);
        run_request(1'b0, {sector_t'(1), offset_t'(20)}, '0);
        check_commands(0, 0);

        // Dirty eviction of sector 1
        mark_counts();
        run_request(1'b0, {sector_t'(6), offset_t'(3)}, '0);
        check_commands(1, 1);
        if (core.wr_arg != (word_t'(1) << SECTOR_BYTE_SHIFT)) begin
            count_errors++;
            $display("Fail t=%0t CMD_ARG got %h expected %h",
                     $time, core.wr_arg, word_t'(1) << SECTOR_BYTE_SHIFT);
        end
        if (core.last_cmd != READ_BLOCK) begin
            count_errors++;
            $display("Fail t=%0t CMD got %0d expected %0d", $time, core.last_cmd, READ_BLOCK);
        end
        // Clean miss back to the old sector
        mark_counts();
        run_request(1'b0, {sector_t'(1), offset_t'(20)}, '0);
        check_commands(1, 0);

        // One failed READ_BLOCK is reissued
        fail_cmd <= 1'b1;
        mark_counts();
        run_request(1'b0, {sector_t'(9), offset_t'(100)}, '0);
        fail_cmd <= 1'b0;
        check_commands(2, 0);
        if (!core.err_used) begin
            count_errors++;
            $display("The command error was never injected");
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            stim_state = lcg_next(stim_state);
            r          = stim_state;
            stim_state = lcg_next(stim_state);
            wdata      = stim_state;
            run_request(r[20], {sector_t'(4 + r[23:22]), offset_t'(r[30:24])}, wdata);
        end

        repeat (4) @(posedge osc_50);
        $display("Reads checked %0d, data errors %0d, command errors %0d, protocol errors %0d",
                 data_reads, data_errors, count_errors, protocol_errors);
        if (data_errors + count_errors + protocol_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* source/avalon_master.sv */
// Registered bus master running one read or write transfer against waitrequest
`timescale 1ns/1ps

module avalon_master (
    input  logic              osc_50,
    input  logic              reset_50m,

    // Operation request from the sequencer
    input  logic              i_start,
    input  logic              i_write,
    input  sd_pkg::reg_addr_t i_address,
    input  sd_pkg::byte_en_t  i_byteenable,
    input  sd_pkg::word_t     i_writedata,
    output logic              o_done,
    output sd_pkg::word_t     o_readdata,

    // Register bus of the SD host core
    output sd_pkg::reg_addr_t o_avm_address,
    output logic              o_avm_read,
    output logic              o_avm_write,
    output sd_pkg::byte_en_t  o_avm_byteenable,
    output sd_pkg::word_t     o_avm_writedata,
    input  sd_pkg::word_t     i_avm_readdata,
    input  logic              i_avm_waitrequest
);

    logic xfer_end;

    // Transfer completes when a strobe is up and the core does not stall
    assign xfer_end = (o_avm_read || o_avm_write) && !i_avm_waitrequest;

    // Strobes and done
    always_ff @(posedge osc_50) begin
        if (reset_50m) begin
            o_avm_read  <= 1'b0;
            o_avm_write <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            o_done <= xfer_end;
            if (i_start) begin
                o_avm_read  <= !i_write;
                o_avm_write <= i_write;
            end else if (xfer_end) begin
                o_avm_read  <= 1'b0;
                o_avm_write <= 1'b0;
            end
        end
    end

    // Operation fields stay put until the next start
    always_ff @(posedge osc_50) begin
        if (i_start) begin
            o_avm_address    <= i_address;
            o_avm_byteenable <= i_byteenable;
            o_avm_writedata  <= i_writedata;
        end
    end

    // Read data is kept until the next read completes
    always_ff @(posedge osc_50) begin
        if (xfer_end && o_avm_read) begin
            o_readdata <= i_avm_readdata;
        end
    end

endmodule

/* source/sd_cache_top.sv */
// Top level of the write-back sector cache between the CPU port and the SD core bus
`timescale 1ns/1ps

module sd_cache_top (
    input  logic               osc_50,
    input  logic               reset_50m,

    // CPU port
    input  logic               i_sd_command,
    input  logic               i_sd_write,
    input  sd_pkg::word_addr_t i_sd_address,
    input  sd_pkg::word_t      i_sd_data_write,
    output logic               o_sd_response,
    output sd_pkg::word_t      o_sd_data_read,

    // SD host core register bus
    output sd_pkg::reg_addr_t  o_avm_address,
    output logic               o_avm_read,
    output logic               o_avm_write,
    output sd_pkg::byte_en_t   o_avm_byteenable,
    output sd_pkg::word_t      o_avm_writedata,
    input  sd_pkg::word_t      i_avm_readdata,
    input  logic               i_avm_waitrequest
);
    import sd_pkg::*;

    logic      hit;
    logic      writeback;
    sector_t   tag_sector;
    logic      load;
    logic      dirty_set;
    logic      dirty_clear;
    logic      start;
    logic      write;
    reg_addr_t address;
    byte_en_t  byteenable;
    word_t     writedata;
    logic      done;
    word_t     readdata;

    sector_tag u_tag (
        .osc_50        (osc_50),
        .reset_50m     (reset_50m),
        .i_req_sector  (i_sd_address[29:7]),
        .i_load        (load),
        .i_dirty_set   (dirty_set),
        .i_dirty_clear (dirty_clear),
        .o_hit         (hit),
        .o_writeback   (writeback),
        .o_tag_sector  (tag_sector)
    );

    sd_sequencer u_seq (
        .osc_50          (osc_50),
        .reset_50m       (reset_50m),
        .i_sd_command    (i_sd_command),
        .i_sd_write      (i_sd_write),
        .i_sd_address    (i_sd_address),
        .i_sd_data_write (i_sd_data_write),
        .o_sd_response   (o_sd_response),
        .o_sd_data_read  (o_sd_data_read),
        .i_hit           (hit),
        .i_writeback     (writeback),
        .i_tag_sector    (tag_sector),
        .o_load          (load),
        .o_dirty_set     (dirty_set),
        .o_dirty_clear   (dirty_clear),
        .o_start         (start),
        .o_write         (write),
        .o_address       (address),
        .o_byteenable    (byteenable),
        .o_writedata     (writedata),
        .i_done          (done),
        .i_readdata      (readdata)
    );

    avalon_master u_bus (
        .osc_50            (osc_50),
        .reset_50m         (reset_50m),
        .i_start           (start),
        .i_write           (write),
        .i_address         (address),
        .i_byteenable      (byteenable),
        .i_writedata       (writedata),
        .o_done            (done),
        .o_readdata        (readdata),
        .o_avm_address     (o_avm_address),
        .o_avm_read        (o_avm_read),
        .o_avm_write       (o_avm_write),
        .o_avm_byteenable  (o_avm_byteenable),
        .o_avm_writedata   (o_avm_writedata),
        .i_avm_readdata    (i_avm_readdata),
        .i_avm_waitrequest (i_avm_waitrequest)
    );

endmodule

/* source/sd_pkg.sv */
// Shared widths, SD core register map, command codes and status bit positions
package sd_pkg;

    // Data word on the CPU port and the core bus
    typedef logic [31:0] word_t;

    // CPU word address and its sector number and word offset parts
    typedef logic [29:0] word_addr_t;
    typedef logic [22:0] sector_t;
    typedef logic [6:0]  offset_t;

    // Core register word address and bus byte enables
    typedef logic [7:0] reg_addr_t;
    typedef logic [3:0] byte_en_t;

    // Core register map in 32-bit word units
    localparam reg_addr_t RXTX_BUFFER = 8'd0;
    localparam reg_addr_t CMD_ARG     = 8'd139;
    localparam reg_addr_t CMD         = 8'd140;
    localparam reg_addr_t ASR         = 8'd141;

    // Block commands understood by the core
    localparam word_t READ_BLOCK  = 32'd17;
    localparam word_t WRITE_BLOCK = 32'd24;

    // Bit positions in the ASR status word
    localparam int ASR_VALID   = 0;
    localparam int ASR_PRESENT = 1;
    localparam int ASR_BUSY    = 2;
    localparam int ASR_ERROR   = 4;

    // Full word lanes, and the low half used for ASR and CMD
    localparam byte_en_t BE_ALL = 4'b1111;
    localparam byte_en_t BE_LOW = 4'b0011;

    // A sector is 512 bytes, so the byte argument is sector << 9
    localparam int SECTOR_BYTE_SHIFT = 9;

endpackage

/* source/sd_sequencer.sv */
// Cache sequencer FSM for start-up polling, write-back, fetch, buffer access and response
`timescale 1ns/1ps

module sd_sequencer (
    input  logic               osc_50,
    input  logic               reset_50m,

    // CPU request port
    input  logic               i_sd_command,
    input  logic               i_sd_write,
    input  sd_pkg::word_addr_t i_sd_address,
    input  sd_pkg::word_t      i_sd_data_write,
    output logic               o_sd_response,
    output sd_pkg::word_t      o_sd_data_read,

    // Tag store
    input  logic               i_hit,
    input  logic               i_writeback,
    input  sd_pkg::sector_t    i_tag_sector,
    output logic               o_load,
    output logic               o_dirty_set,
    output logic               o_dirty_clear,

    // Bus master
    output logic               o_start,
    output logic               o_write,
    output sd_pkg::reg_addr_t  o_address,
    output sd_pkg::byte_en_t   o_byteenable,
    output sd_pkg::word_t      o_writedata,
    input  logic               i_done,
    input  sd_pkg::word_t      i_readdata
);
    import sd_pkg::*;

    typedef enum logic [3:0] {
        ST_BOOT_POLL,
        ST_BOOT_CHECK,
        ST_IDLE,
        ST_ARG,
        ST_CMD,
        ST_POLL,
        ST_CHECK,
        ST_ACCESS,
        ST_FINISH,
        ST_RESPOND,
        ST_WAIT,
        ST_GAP
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_next;
    seq_state_t ret_state;
    seq_state_t ret_next;
    logic       wb_phase;
    logic       wb_next;
    logic       status_retry;
    sector_t    req_sector;
    offset_t    req_offset;
    sector_t    arg_sector;

    assign req_offset = i_sd_address[$bits(offset_t)-1:0];
    assign req_sector = i_sd_address[$bits(word_addr_t)-1:$bits(offset_t)];

    // Write-back uses the buffered sector, a fetch uses the requested one
    assign arg_sector = wb_phase ? i_tag_sector : req_sector;

    // Command failed or card went missing
    assign status_retry = !i_readdata[ASR_VALID] || !i_readdata[ASR_PRESENT] ||
                          i_readdata[ASR_ERROR];

    always_comb begin
        state_next    = state;
        ret_next      = ret_state;
        wb_next       = wb_phase;
        o_start       = 1'b0;
        o_write       = 1'b0;
        o_address     = ASR;
        o_byteenable  = BE_LOW;
        o_writedata   = '0;
        o_load        = 1'b0;
        o_dirty_set   = 1'b0;
        o_dirty_clear = 1'b0;

        case (state)
            ST_BOOT_POLL: begin
                o_start    = 1'b1;
                ret_next   = ST_BOOT_CHECK;
                state_next = ST_WAIT;
            end
            ST_BOOT_CHECK: begin
                state_next = i_readdata[ASR_PRESENT] ? ST_IDLE : ST_BOOT_POLL;
            end
            ST_IDLE: begin
                if (i_sd_command) begin
                    if (i_hit) begin
                        state_next = ST_ACCESS;
                    end else begin
                        wb_next    = i_writeback;
                        state_next = ST_ARG;
                    end
                end
            end
            ST_ARG: begin
                o_start      = 1'b1;
                o_write      = 1'b1;
                o_address    = CMD_ARG;
                o_byteenable = BE_ALL;
                o_writedata  = word_t'(arg_sector) << SECTOR_BYTE_SHIFT;
                ret_next     = ST_CMD;
                state_next   = ST_WAIT;
            end
            ST_CMD: begin
                o_start     = 1'b1;
                o_write     = 1'b1;
                o_address   = CMD;
                o_writedata = wb_phase ? WRITE_BLOCK : READ_BLOCK;
                ret_next    = ST_POLL;
                state_next  = ST_WAIT;
            end
            ST_POLL: begin
                o_start    = 1'b1;
                ret_next   = ST_CHECK;
                state_next = ST_WAIT;
            end
            ST_CHECK: begin
                if (status_retry) begin
                    // Reissue the whole command
                    state_next = ST_ARG;
                end else if (i_readdata[ASR_BUSY]) begin
                    state_next = ST_POLL;
                end else if (wb_phase) begin
                    // Old sector is on the card so fetch the new one
                    o_dirty_clear = 1'b1;
                    wb_next       = 1'b0;
                    state_next    = ST_ARG;
                end else begin
                    o_load     = 1'b1;
                    state_next = ST_ACCESS;
                end
            end
            ST_ACCESS: begin
                o_start      = 1'b1;
                o_write      = i_sd_write;
                o_address    = RXTX_BUFFER + reg_addr_t'(req_offset);
                o_byteenable = BE_ALL;
                o_writedata  = i_sd_data_write;
                ret_next     = ST_FINISH;
                state_next   = ST_WAIT;
            end
            ST_FINISH: begin
                o_dirty_set = i_sd_write;
                state_next  = ST_RESPOND;
            end
            ST_RESPOND: begin
                if (!i_sd_command) begin
                    state_next = ST_IDLE;
                end
            end
            ST_WAIT: begin
                if (i_done) begin
                    state_next = ST_GAP;
                end
            end
            ST_GAP: begin
                // Idle bus cycle between transfers
                state_next = ret_state;
            end
            default: begin
                state_next = ST_BOOT_POLL;
            end
        endcase
    end

    always_ff @(posedge osc_50) begin
        if (reset_50m) begin
            state         <= ST_BOOT_POLL;
            ret_state     <= ST_BOOT_CHECK;
            wb_phase      <= 1'b0;
            o_sd_response <= 1'b0;
        end else begin
            state     <= state_next;
            ret_state <= ret_next;
            wb_phase  <= wb_next;
            if (state == ST_FINISH) begin
                o_sd_response <= 1'b1;
            end else if (state == ST_RESPOND && !i_sd_command) begin
                o_sd_response <= 1'b0;
            end
        end
    end

    // Read result held from the response until the next read finishes
    always_ff @(posedge osc_50) begin
        if (state == ST_FINISH && !i_sd_write) begin
            o_sd_data_read <= i_readdata;
        end
    end

endmodule

/* source/sector_tag.sv */
// Sector tag with valid and dirty flags, plus hit and write-back decisions
`timescale 1ns/1ps

module sector_tag (
    input  logic            osc_50,
    input  logic            reset_50m,
    input  sd_pkg::sector_t i_req_sector,
    input  logic            i_load,
    input  logic            i_dirty_set,
    input  logic            i_dirty_clear,
    output logic            o_hit,
    output logic            o_writeback,
    output sd_pkg::sector_t o_tag_sector
);
    import sd_pkg::*;

    sector_t tag_sector;
    logic    valid;
    logic    dirty;

    // Valid and dirty flags of the buffered sector
    always_ff @(posedge osc_50) begin
        if (reset_50m) begin
            valid <= 1'b0;
            dirty <= 1'b0;
        end else begin
            if (i_load) begin
                valid <= 1'b1;
            end
            // A finished write-back wins over a buffer write
            if (i_dirty_clear) begin
                dirty <= 1'b0;
            end else if (i_dirty_set) begin
                dirty <= 1'b1;
            end
        end
    end

    // Sector number of the data now held in the transfer buffer
    always_ff @(posedge osc_50) begin
        if (i_load) begin
            tag_sector <= i_req_sector;
        end
    end

    assign o_hit        = valid && (tag_sector == i_req_sector);
    assign o_writeback  = valid && dirty && !o_hit;
    assign o_tag_sector = tag_sector;

endmodule

/* sources.f */
source/sd_pkg.sv
source/sector_tag.sv
source/avalon_master.sv
source/sd_sequencer.sv
source/sd_cache_top.sv
sim/sd_core_model.sv
sim/sd_cache_props.sv
sim/tb_sd_cache.sv
